// ==== filelist.f ====
+incdir+verif
design/cpu6_bus_pkg.sv
design/wait_timer.sv
design/bus_sequencer.sv
design/address_unit.sv
design/page_table.sv
design/bus_data_path.sv
design/cpu6_bus_unit.sv
verif/tb_cpu6_bus_unit.sv

// ==== Makefile ====
SOURCES := filelist.f $(wildcard design/*.sv verif/*.sv verif/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_cpu6_bus_unit
	@out="$$(./obj_dir/Vtb_cpu6_bus_unit)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

obj_dir/Vtb_cpu6_bus_unit: $(SOURCES)
	verilator --binary --timing --assert --top-module tb_cpu6_bus_unit -f filelist.f

clean:
	rm -rf obj_dir

// ==== verif/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Expected page table, MAR and base register
frame_t        pte_mirror[256];
logical_addr_t mar_mirror;
ptb_t          ptb_mirror;
logic [15:0]   lfsr_state = 16'd67;

int    error_count;
int    check_count;
int    tests_run;
int    tests_failed;
int    errors_at_start;
string current_test;

// Index is page number above base register
function automatic phys_addr_t ref_phys_addr(input logical_addr_t mar, input ptb_t ptb);
    return {pte_mirror[{mar[15:11], ptb}], mar[10:0]};
endfunction

function automatic byte_t ref_mem_byte(input phys_addr_t addr);
    return addr[7:0] ^ addr[18:11];  // Low address byte XOR frame
endfunction

// Taps 16, 14, 13, 11
function automatic byte_t rand_byte();
    byte_t value;
    logic  feedback;
    value = '0;
    for (int i = 0; i < 8; i++) begin
        feedback   = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], feedback};
        value      = {value[6:0], feedback};
    end
    return value;
endfunction

task automatic check_phys(input string what, input phys_addr_t expected,
                          input phys_addr_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("ERROR %s: %s expected 0x%05h actual 0x%05h",
                 current_test, what, expected, actual);
    end
endtask

task automatic check_byte(input string what, input byte_t expected, input byte_t actual);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("ERROR %s: %s expected 0x%02h actual 0x%02h",
                 current_test, what, expected, actual);
    end
endtask

task automatic report_problem(input string msg);
    error_count++;
    $display("%s: %s", current_test, msg);
endtask

task automatic start_test(input string name);
    current_test    = name;
    errors_at_start = error_count;
    tests_run++;
endtask

task automatic end_test();
    if (error_count == errors_at_start) begin
        $display("%-16s ok", current_test);
    end else begin
        tests_failed++;
        $display("%-16s failed with %0d errors", current_test, error_count - errors_at_start);
    end
endtask

`endif

// ==== verif/tb_cpu6_bus_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cpu6_bus_unit;
    import cpu6_bus_pkg::*;

    localparam int WAIT_STATES    = 2;
    localparam int TIMEOUT_CYCLES = 40 * (WAIT_STATES + 6) + 100;  // 40 commands at most

    logic       clock;
    logic       reset;
    logic       cmd_valid;
    bus_op_t    cmd_op;
    byte_t      cmd_data;
    logic       rsp_ready;
    byte_t      data_in;
    logic       cmd_ready;
    logic       rsp_valid;
    byte_t      rsp_data;
    phys_addr_t address_bus;
    byte_t      data_out;
    logic       write_en;

    int         cycle_count;
    int         rsp_cycle;     // Last response transfer
    int         accept_cycle;  // Last command acceptance
    phys_addr_t write_addr_q[$];
    byte_t      write_data_q[$];
    byte_t      read_data_q[$];

    `include "tb_ref_model.svh"

    cpu6_bus_unit #(.WAIT_STATES(WAIT_STATES)) DUT (.*);

    assign data_in = address_bus[7:0] ^ address_bus[18:11];  // Memory model

    always #50 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the bus stopped answering", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Compares every strobe and every response transfer
    always @(negedge clock) begin
        if (!reset && write_en) begin
            if (write_addr_q.size() == 0) begin
                report_problem("write strobe with no write outstanding");
            end else begin
                check_phys("write address", write_addr_q.pop_front(), address_bus);
                check_byte("write data", write_data_q.pop_front(), data_out);
            end
        end
        if (!reset && rsp_valid && rsp_ready) begin
            rsp_cycle = cycle_count;
            if (read_data_q.size() == 0) begin
                report_problem("response with no read outstanding");
            end else begin
                check_byte("read data", read_data_q.pop_front(), rsp_data);
            end
        end
    end

    task automatic update_model(input bus_op_t op, input byte_t data);
        phys_addr_t addr;
        addr = ref_phys_addr(mar_mirror, ptb_mirror);
        case (op)
            OP_LOAD_HI:   mar_mirror[15:8] = data;
            OP_LOAD_LO:   mar_mirror[7:0] = data;
            OP_SET_PTB:   ptb_mirror = data[2:0];
            OP_WRITE_PTE: pte_mirror[{mar_mirror[15:11], ptb_mirror}] = data;
            OP_READ: begin
                read_data_q.push_back(ref_mem_byte(addr));
                mar_mirror = mar_mirror + logical_addr_t'(1);
            end
            OP_WRITE: begin
                write_addr_q.push_back(addr);
                write_data_q.push_back(data);
                mar_mirror = mar_mirror + logical_addr_t'(1);
            end
            default: report_problem("unknown opcode issued");
        endcase
    endtask

    task automatic send_cmd(input bus_op_t op, input byte_t data);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_data  = data;
        @(negedge clock);
        while (!cmd_ready) begin
            @(negedge clock);
        end
        accept_cycle = cycle_count;
        update_model(op, data);
        @(posedge clock);  // Accepting edge
        #5;
        cmd_valid = 1'b0;
    endtask

    task automatic probe_address(input string what);
        @(negedge clock);
        check_phys(what, ref_phys_addr(mar_mirror, ptb_mirror), address_bus);
        @(posedge clock);
        #5;
    endtask

    task automatic wait_idle();
        @(negedge clock);
        while (!cmd_ready || write_addr_q.size() != 0 || read_data_q.size() != 0) begin
            @(negedge clock);
        end
        @(posedge clock);
        #5;
    endtask

    initial begin
        byte_t held;
        clock        = 1'b0;
        reset        = 1'b1;
        cmd_valid    = 1'b0;
        cmd_op       = OP_LOAD_HI;
        cmd_data     = '0;
        rsp_ready    = 1'b1;
        cycle_count  = 0;
        rsp_cycle    = 0;
        accept_cycle = 0;
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        mar_mirror   = '0;
        ptb_mirror   = '0;
        current_test = "reset";
        repeat (2) @(posedge clock);
        #5;
        reset = 1'b0;

        start_test("translation");
        send_cmd(OP_SET_PTB, 8'h00);
        send_cmd(OP_LOAD_HI, 8'h00);
        send_cmd(OP_WRITE_PTE, rand_byte());
        send_cmd(OP_LOAD_HI, 8'h08);
        send_cmd(OP_WRITE_PTE, rand_byte());
        send_cmd(OP_LOAD_HI, 8'h5a);
        send_cmd(OP_WRITE_PTE, rand_byte());
        send_cmd(OP_LOAD_LO, 8'h3c);
        probe_address("page 11 address");
        send_cmd(OP_LOAD_HI, 8'h08);
        send_cmd(OP_LOAD_LO, 8'h12);
        probe_address("page 1 address");
        end_test();

        start_test("read_data");
        send_cmd(OP_READ, 8'h00);
        send_cmd(OP_READ, 8'h00);
        wait_idle();
        end_test();

        start_test("write_strobe");
        send_cmd(OP_WRITE, rand_byte());
        send_cmd(OP_WRITE, rand_byte());
        wait_idle();
        probe_address("address after writes");
        end_test();

        start_test("auto_increment");
        send_cmd(OP_LOAD_HI, 8'h07);
        send_cmd(OP_LOAD_LO, 8'hfe);
        repeat (3) send_cmd(OP_READ, 8'h00);  // Third read lands in page 1
        wait_idle();
        probe_address("address after reads");
        end_test();

        start_test("base_register");
        send_cmd(OP_SET_PTB, 8'h01);
        send_cmd(OP_LOAD_HI, 8'h08);
        send_cmd(OP_WRITE_PTE, ~pte_mirror[8'd8]);  // Differs from the base 0 entry
        send_cmd(OP_LOAD_LO, 8'h40);
        probe_address("base 1 address");
        send_cmd(OP_READ, 8'h00);
        wait_idle();
        send_cmd(OP_SET_PTB, 8'h00);
        send_cmd(OP_LOAD_LO, 8'h40);
        probe_address("base 0 address");
        send_cmd(OP_READ, 8'h00);
        wait_idle();
        end_test();

        start_test("back_pressure");
        rsp_ready = 1'b0;
        send_cmd(OP_READ, 8'h00);
        @(negedge clock);
        while (!rsp_valid) begin
            @(negedge clock);
        end
        held = rsp_data;
        @(posedge clock);
        #5;
        cmd_valid = 1'b1;  // Next command waits behind the response
        cmd_op    = OP_LOAD_LO;
        cmd_data  = 8'h20;
        repeat (4) begin
            @(negedge clock);
            if (!rsp_valid) report_problem("rsp_valid dropped without rsp_ready");
            if (cmd_ready) report_problem("cmd_ready rose while the response was pending");
            check_byte("held response", held, rsp_data);
        end
        @(posedge clock);
        #5;
        rsp_ready = 1'b1;
        send_cmd(OP_LOAD_LO, 8'h20);
        if (accept_cycle <= rsp_cycle) begin
            report_problem("command accepted before the response transferred");
        end
        send_cmd(OP_READ, 8'h00);
        wait_idle();
        end_test();

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/cpu6_bus_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu6_bus_unit #(
    parameter int WAIT_STATES = 2
) (
    input  wire                        clock,
    input  wire                        reset,
    input  wire                        cmd_valid,
    input  wire cpu6_bus_pkg::bus_op_t cmd_op,
    input  wire cpu6_bus_pkg::byte_t   cmd_data,
    input  wire                        rsp_ready,
    input  wire cpu6_bus_pkg::byte_t   data_in,
    output logic                       cmd_ready,
    output logic                       rsp_valid,
    output cpu6_bus_pkg::byte_t        rsp_data,
    output cpu6_bus_pkg::phys_addr_t   address_bus,
    output cpu6_bus_pkg::byte_t        data_out,
    output logic                       write_en
);
    import cpu6_bus_pkg::*;

    logic          timer_start;
    logic          expired;
    logic          load_hi;
    logic          load_lo;
    logic          load_ptb;
    logic          pte_write;
    logic          mar_increment;
    logic          capture_read;
    logic          capture_write;
    logic          strobe_write;
    logical_addr_t mar;
    ptb_t          ptb;

    bus_sequencer #(
        .WAIT_STATES(WAIT_STATES)
    ) u_sequencer (
        .clock        (clock),
        .reset        (reset),
        .cmd_valid    (cmd_valid),
        .cmd_op       (cmd_op),
        .rsp_ready    (rsp_ready),
        .expired      (expired),
        .cmd_ready    (cmd_ready),
        .rsp_valid    (rsp_valid),
        .timer_start  (timer_start),
        .load_hi      (load_hi),
        .load_lo      (load_lo),
        .load_ptb     (load_ptb),
        .pte_write    (pte_write),
        .mar_increment(mar_increment),
        .capture_read (capture_read),
        .capture_write(capture_write),
        .strobe_write (strobe_write)
    );

    wait_timer #(
        .WAIT_STATES(WAIT_STATES)
    ) u_timer (
        .clock  (clock),
        .reset  (reset),
        .start  (timer_start),
        .expired(expired)
    );

    address_unit u_address (
        .clock        (clock),
        .reset        (reset),
        .load_hi      (load_hi),
        .load_lo      (load_lo),
        .load_ptb     (load_ptb),
        .mar_increment(mar_increment),
        .load_data    (cmd_data),
        .mar          (mar),
        .ptb          (ptb)
    );

    // Frame byte comes straight from the command data
    page_table u_page_table (
        .clock      (clock),
        .pte_write  (pte_write),
        .pte_data   (cmd_data),
        .mar        (mar),
        .ptb        (ptb),
        .address_bus(address_bus)
    );

    bus_data_path u_data_path (
        .clock        (clock),
        .reset        (reset),
        .capture_write(capture_write),
        .strobe_write (strobe_write),
        .capture_read (capture_read),
        .cmd_data     (cmd_data),
        .data_in      (data_in),
        .data_out     (data_out),
        .write_en     (write_en),
        .rsp_data     (rsp_data)
    );

endmodule

`default_nettype wire

// ==== design/bus_data_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_data_path (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       capture_write,
    input  wire                       strobe_write,
    input  wire                       capture_read,
    input  wire cpu6_bus_pkg::byte_t  cmd_data,
    input  wire cpu6_bus_pkg::byte_t  data_in,
    output cpu6_bus_pkg::byte_t       data_out,
    output logic                      write_en,
    output cpu6_bus_pkg::byte_t       rsp_data
);
    // Write byte held from acceptance through the strobe
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            data_out <= '0;
        end else if (capture_write) begin
            data_out <= cmd_data;
        end
    end

    // One-cycle strobe
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            write_en <= 1'b0;
        end else begin
            write_en <= strobe_write;
        end
    end

    // Read byte, stays put while the response waits
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            rsp_data <= '0;
        end else if (capture_read) begin
            rsp_data <= data_in;
        end
    end

endmodule

`default_nettype wire

// ==== design/page_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module page_table (
    input  wire                               clock,
    input  wire                               pte_write,
    input  wire cpu6_bus_pkg::frame_t         pte_data,
    input  wire cpu6_bus_pkg::logical_addr_t  mar,
    input  wire cpu6_bus_pkg::ptb_t           ptb,
    output cpu6_bus_pkg::phys_addr_t          address_bus
);
    import cpu6_bus_pkg::*;

    localparam int PAGE_BITS   = LOGICAL_ADDR_WIDTH - PAGE_OFFSET_WIDTH;
    localparam int INDEX_WIDTH = PAGE_BITS + PTB_WIDTH;
    localparam int ENTRIES     = 1 << INDEX_WIDTH;

    frame_t                 frames [ENTRIES];
    logic [INDEX_WIDTH-1:0] index;
    frame_t                 frame;

    // Page number above base register bits
    assign index = {mar[LOGICAL_ADDR_WIDTH-1 -: PAGE_BITS], ptb};

    always_ff @(posedge clock) begin
        if (pte_write) begin
            frames[index] <= pte_data;
        end
    end

    // Asynchronous lookup
    assign frame       = frames[index];
    assign address_bus = {frame, mar[PAGE_OFFSET_WIDTH-1:0]};

endmodule

`default_nettype wire

// ==== design/address_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module address_unit (
    input  wire                          clock,
    input  wire                          reset,
    input  wire                          load_hi,
    input  wire                          load_lo,
    input  wire                          load_ptb,
    input  wire                          mar_increment,
    input  wire cpu6_bus_pkg::byte_t     load_data,
    output cpu6_bus_pkg::logical_addr_t  mar,
    output cpu6_bus_pkg::ptb_t           ptb
);
    import cpu6_bus_pkg::*;

    // Memory address register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            mar <= '0;
        end else if (load_hi) begin
            mar[LOGICAL_ADDR_WIDTH-1 -: DATA_WIDTH] <= load_data;
        end else if (load_lo) begin
            mar[DATA_WIDTH-1:0] <= load_data;
        end else if (mar_increment) begin
            mar <= mar + 1'b1;  // Wraps at 16 bits
        end
    end

    // Page table base register
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ptb <= '0;
        end else if (load_ptb) begin
            ptb <= load_data[PTB_WIDTH-1:0];
        end
    end

    // Loads come only from idle, increments only from a bus cycle
    a_load_vs_inc: assert property (@(posedge clock) disable iff (reset)
        (load_hi || load_lo) |-> !mar_increment);

endmodule

`default_nettype wire

// ==== design/bus_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_sequencer #(
    parameter int WAIT_STATES = 2
) (
    input  wire                   clock,
    input  wire                   reset,
    input  wire                   cmd_valid,
    input  wire cpu6_bus_pkg::bus_op_t cmd_op,
    input  wire                   rsp_ready,
    input  wire                   expired,
    output logic                  cmd_ready,
    output logic                  rsp_valid,
    output logic                  timer_start,
    output logic                  load_hi,
    output logic                  load_lo,
    output logic                  load_ptb,
    output logic                  pte_write,
    output logic                  mar_increment,
    output logic                  capture_read,
    output logic                  capture_write,
    output logic                  strobe_write
);
    import cpu6_bus_pkg::*;

    bus_state_t state;
    logic       cycle_is_read;  // Opcode kept from acceptance
    logic       accept;

    assign cmd_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_RESPOND);
    assign accept    = cmd_valid && cmd_ready;

    // Single-cycle commands act on the accepting edge
    assign load_hi   = accept && (cmd_op == OP_LOAD_HI);
    assign load_lo   = accept && (cmd_op == OP_LOAD_LO);
    assign load_ptb  = accept && (cmd_op == OP_SET_PTB);
    assign pte_write = accept && (cmd_op == OP_WRITE_PTE);

    assign timer_start   = accept && ((cmd_op == OP_READ) || (cmd_op == OP_WRITE));
    assign capture_write = accept && (cmd_op == OP_WRITE);

    // End of the wait
    assign capture_read  = (state == ST_WAIT) && expired && cycle_is_read;
    assign strobe_write  = (state == ST_WAIT) && expired && !cycle_is_read;

    // Reads step the MAR as data is sampled, writes after the strobe
    assign mar_increment = capture_read || (state == ST_STROBE);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= ST_IDLE;
            cycle_is_read <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (timer_start) begin
                        state         <= ST_WAIT;
                        cycle_is_read <= (cmd_op == OP_READ);
                    end
                end
                ST_WAIT: begin
                    if (expired) begin
                        state <= cycle_is_read ? ST_RESPOND : ST_STROBE;
                    end
                end
                ST_STROBE:  state <= ST_IDLE;  // write_en cycle
                ST_RESPOND: begin
                    if (rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // Response is held until the host takes it
    a_rsp_hold: assert property (@(posedge clock) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid);

    // The write_en cycle follows strobe_write and must not overlap a response
    a_strobe_no_rsp: assert property (@(posedge clock) disable iff (reset)
        strobe_write |=> !rsp_valid);

    // Timer answers exactly WAIT_STATES cycles after it is started
    a_wait_length: assert property (@(posedge clock) disable iff (reset)
        timer_start |-> ##WAIT_STATES expired);

endmodule

`default_nettype wire

// ==== design/wait_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module wait_timer #(
    parameter int WAIT_STATES = 2
) (
    input  wire  clock,
    input  wire  reset,
    input  wire  start,
    output logic expired
);
    localparam int COUNT_WIDTH = $clog2(WAIT_STATES + 1);

    logic [COUNT_WIDTH-1:0] count;
    logic                   running;

    // Last wait cycle
    assign expired = running && (count == '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count   <= '0;
            running <= 1'b0;
        end else if (start) begin
            count   <= COUNT_WIDTH'(WAIT_STATES - 1);  // Zero is the final cycle
            running <= 1'b1;
        end else if (expired) begin
            running <= 1'b0;
        end else if (running) begin
            count <= count - 1'b1;
        end
    end

    // One bus cycle at a time
    a_no_restart: assert property (@(posedge clock) disable iff (reset)
        start |-> !running);

endmodule

`default_nettype wire

// ==== design/cpu6_bus_pkg.sv ====
`default_nettype none

package cpu6_bus_pkg;

    localparam int DATA_WIDTH         = 8;
    localparam int LOGICAL_ADDR_WIDTH = 16;
    localparam int PAGE_OFFSET_WIDTH  = 11;  // Low MAR bits, untranslated
    localparam int PTB_WIDTH          = 3;
    localparam int PHYS_ADDR_WIDTH    = 19;

    typedef logic [DATA_WIDTH-1:0]                         byte_t;
    typedef logic [LOGICAL_ADDR_WIDTH-1:0]                 logical_addr_t;
    typedef logic [PHYS_ADDR_WIDTH-PAGE_OFFSET_WIDTH-1:0]  frame_t;  // Physical bits 18:11
    typedef logic [PTB_WIDTH-1:0]                          ptb_t;
    typedef logic [PHYS_ADDR_WIDTH-1:0]                    phys_addr_t;

    // Host command opcodes
    typedef enum logic [2:0] {
        OP_LOAD_HI   = 3'd0,  // MAR high byte
        OP_LOAD_LO   = 3'd1,  // MAR low byte
        OP_SET_PTB   = 3'd2,  // Base register from data[2:0]
        OP_WRITE_PTE = 3'd3,  // Frame for current index
        OP_READ      = 3'd4,
        OP_WRITE     = 3'd5
    } bus_op_t;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_WAIT    = 2'd1,
        ST_STROBE  = 2'd2,
        ST_RESPOND = 2'd3
    } bus_state_t;

endpackage

`default_nettype wire
